// ==== rob_core_cfg_pkg.sv ====
`default_nettype none

package rob_core_cfg_pkg;

    // reorder buffer
    localparam int rob_len   = 8;
    localparam int rob_tag_w = 3;   // log2 of rob_len
    localparam int rob_cnt_w = 4;   // holds 0 .. rob_len

    // architectural registers
    localparam int reg_len   = 32;
    localparam int reg_idx_w = 5;

    localparam int xlen = 32;       // data path width

    // hardwired zero, never written
    localparam logic [reg_idx_w-1:0] zero_reg = '0;

endpackage

`default_nettype wire

// ==== rob_core_op_pkg.sv ====
`default_nettype none

package rob_core_op_pkg;

    typedef enum logic [2:0] {
        op_and,
        op_xor,
        op_add,
        op_sub,
        op_branch       // predicted not-taken
    } alu_op_t;

    typedef enum logic [1:0] {
        entry_free,
        entry_busy,     // waiting for its cdb result
        entry_done
    } entry_state_t;

    localparam int max_latency = 3;

    // cycles from issue until the result is on the cdb
    function automatic logic [1:0] op_latency(input alu_op_t op);
        case (op)
            op_and, op_xor: return 2'd1;
            op_add, op_sub: return 2'd2;
            default:        return 2'd3;   // branch compare
        endcase
    endfunction

endpackage

`default_nettype wire

// ==== rob_entry.sv ====
`timescale 1ns/100ps
`default_nettype none

module rob_entry (
    input  logic                                   clock,
    input  logic                                   reset,
    input  logic                                   alloc,
    input  logic [rob_core_cfg_pkg::reg_idx_w-1:0] alloc_dest,
    input  logic                                   alloc_branch,
    input  logic                                   wb,
    input  logic [rob_core_cfg_pkg::xlen-1:0]      wb_value,
    input  logic                                   wb_mispredict,
    input  logic                                   clear,
    output rob_core_op_pkg::entry_state_t          state,
    output logic [rob_core_cfg_pkg::reg_idx_w-1:0] dest,
    output logic [rob_core_cfg_pkg::xlen-1:0]      value,
    output logic                                   is_branch,
    output logic                                   mispredict
);

    import rob_core_op_pkg::*;

    // slot life cycle, clear wins over everything
    always_ff @(posedge clock) begin
        if (reset) begin
            state <= entry_free;
        end else if (clear) begin
            state <= entry_free;               // retired or squashed
        end else if (alloc) begin
            state <= entry_busy;
        end else if (wb && state == entry_busy) begin
            state <= entry_done;
        end
    end

    // destination and kind captured at dispatch
    always_ff @(posedge clock) begin
        if (alloc) begin
            dest      <= alloc_dest;
            is_branch <= alloc_branch;
        end
    end

    // result from the cdb
    always_ff @(posedge clock) begin
        if (wb) begin
            value      <= wb_value;
            mispredict <= wb_mispredict;
        end
    end

endmodule

`default_nettype wire

// ==== rob.sv ====
`timescale 1ns/100ps
`default_nettype none

module rob (
    input  logic                                   clock,
    input  logic                                   reset,
    // dispatch
    input  logic                                   disp_valid,
    input  rob_core_op_pkg::alu_op_t               disp_op,
    input  logic [rob_core_cfg_pkg::reg_idx_w-1:0] disp_dest,
    input  logic [rob_core_cfg_pkg::xlen-1:0]      disp_a,
    input  logic [rob_core_cfg_pkg::xlen-1:0]      disp_b,
    output logic                                   disp_ready,
    // issue to the execution unit
    input  logic                                   slot_free,
    output logic                                   issue_valid,
    output logic [rob_core_cfg_pkg::rob_tag_w-1:0] issue_tag,
    output rob_core_op_pkg::alu_op_t               issue_op,
    output logic [rob_core_cfg_pkg::xlen-1:0]      issue_a,
    output logic [rob_core_cfg_pkg::xlen-1:0]      issue_b,
    // common data bus
    input  logic                                   cdb_valid,
    input  logic [rob_core_cfg_pkg::rob_tag_w-1:0] cdb_tag,
    input  logic [rob_core_cfg_pkg::xlen-1:0]      cdb_value,
    input  logic                                   cdb_mispredict,
    // retire
    output logic                                   commit_valid,
    output logic [rob_core_cfg_pkg::reg_idx_w-1:0] commit_dest,
    output logic [rob_core_cfg_pkg::xlen-1:0]      commit_value,
    output logic                                   commit_squash,
    output logic                                   commit_write,
    output logic                                   flush
);

    import rob_core_cfg_pkg::*;
    import rob_core_op_pkg::*;

    logic [rob_tag_w-1:0] head;
    logic [rob_tag_w-1:0] tail;
    logic [rob_cnt_w-1:0] count;
    logic                 full;
    logic                 accept;
    logic                 retire;
    logic                 squash;

    entry_state_t         ent_state [rob_len];
    logic [reg_idx_w-1:0] ent_dest [rob_len];
    logic [xlen-1:0]      ent_value [rob_len];
    logic [rob_len-1:0]   ent_branch;
    logic [rob_len-1:0]   ent_mispredict;
    logic [rob_len-1:0]   ent_alloc;
    logic [rob_len-1:0]   ent_wb;
    logic [rob_len-1:0]   ent_clear;

    assign full       = (count == rob_cnt_w'(rob_len));
    assign disp_ready = !full && slot_free && !squash;
    assign accept     = disp_valid && disp_ready;

    // issue goes out in the same cycle as allocation
    assign issue_valid = accept;
    assign issue_tag   = tail;
    assign issue_op    = disp_op;
    assign issue_a     = disp_a;
    assign issue_b     = disp_b;

    // head retires as soon as its result is in
    assign retire = (ent_state[head] == entry_done);
    assign squash = retire && ent_branch[head] && ent_mispredict[head];

    // per-slot strobes from tail, cdb tag and head
    always_comb begin
        for (int i = 0; i < rob_len; i++) begin
            ent_alloc[i] = accept && (tail == rob_tag_w'(i));
            ent_wb[i]    = cdb_valid && (cdb_tag == rob_tag_w'(i));
            ent_clear[i] = squash || (retire && head == rob_tag_w'(i));
        end
    end

    for (genvar g = 0; g < rob_len; g++) begin : g_entry
        rob_entry rob_entry_inst (
            .clock         (clock),
            .reset         (reset),
            .alloc         (ent_alloc[g]),
            .alloc_dest    (disp_dest),
            .alloc_branch  (disp_op == op_branch),
            .wb            (ent_wb[g]),
            .wb_value      (cdb_value),
            .wb_mispredict (cdb_mispredict),
            .clear         (ent_clear[g]),
            .state         (ent_state[g]),
            .dest          (ent_dest[g]),
            .value         (ent_value[g]),
            .is_branch     (ent_branch[g]),
            .mispredict    (ent_mispredict[g])
        );
    end

    assign commit_valid  = retire;
    assign commit_squash = squash;
    assign commit_dest   = ent_dest[head];
    assign commit_value  = ent_value[head];
    assign commit_write  = retire && !ent_branch[head] && (ent_dest[head] != zero_reg);
    assign flush         = squash;   // empties the execution slots too

    // pointers wrap naturally, rob_len is a power of two
    always_ff @(posedge clock) begin
        if (reset || squash) begin
            head  <= '0;
            tail  <= '0;
            count <= '0;
        end else begin
            if (retire) begin
                head <= head + 1'b1;
            end
            if (accept) begin
                tail <= tail + 1'b1;
            end
            count <= count + rob_cnt_w'(accept) - rob_cnt_w'(retire);
        end
    end

endmodule

`default_nettype wire

// ==== exec_unit.sv ====
`timescale 1ns/100ps
`default_nettype none

module exec_unit (
    input  logic                                   clock,
    input  logic                                   reset,
    input  logic                                   flush,
    input  logic                                   issue_valid,
    input  logic [rob_core_cfg_pkg::rob_tag_w-1:0] issue_tag,
    input  rob_core_op_pkg::alu_op_t               issue_op,
    input  logic [rob_core_cfg_pkg::xlen-1:0]      issue_a,
    input  logic [rob_core_cfg_pkg::xlen-1:0]      issue_b,
    output logic                                   slot_free,
    output logic                                   cdb_valid,
    output logic [rob_core_cfg_pkg::rob_tag_w-1:0] cdb_tag,
    output logic [rob_core_cfg_pkg::xlen-1:0]      cdb_value,
    output logic                                   cdb_mispredict
);

    import rob_core_cfg_pkg::*;
    import rob_core_op_pkg::*;

    // slot 0 drives the cdb, everything shifts down one per cycle
    logic [max_latency-1:0] slot_valid;
    logic [rob_tag_w-1:0]   slot_tag [max_latency];
    logic [xlen-1:0]        slot_value [max_latency];
    logic [max_latency-1:0] slot_mispredict;

    logic [1:0]             issue_lat;
    logic [1:0]             issue_pos;
    logic [xlen-1:0]        issue_result;
    logic                   issue_mispredict;

    assign issue_lat = op_latency(issue_op);
    assign issue_pos = issue_lat - 2'd1;   // lands here, reaches slot 0 after lat-1 shifts

    always_comb begin
        issue_result     = '0;
        issue_mispredict = 1'b0;
        case (issue_op)
            op_and:    issue_result = issue_a & issue_b;
            op_xor:    issue_result = issue_a ^ issue_b;
            op_add:    issue_result = issue_a + issue_b;
            op_sub:    issue_result = issue_a - issue_b;
            op_branch: issue_mispredict = (issue_a == issue_b);   // taken, not predicted
            default:   issue_result = '0;
        endcase
    end

    // target is blocked if the slot above will shift into it
    always_comb begin
        slot_free = 1'b1;   // top slot has nothing above it
        if (issue_lat < max_latency) begin
            slot_free = !slot_valid[issue_lat];
        end
    end

    always_ff @(posedge clock) begin
        if (reset || flush) begin
            slot_valid <= '0;
        end else begin
            slot_valid <= slot_valid >> 1;
            if (issue_valid) begin
                slot_valid[issue_pos] <= 1'b1;
            end
        end
    end

    always_ff @(posedge clock) begin
        for (int i = 0; i < max_latency - 1; i++) begin
            slot_tag[i]        <= slot_tag[i + 1];
            slot_value[i]      <= slot_value[i + 1];
            slot_mispredict[i] <= slot_mispredict[i + 1];
        end
        if (issue_valid) begin
            slot_tag[issue_pos]        <= issue_tag;
            slot_value[issue_pos]      <= issue_result;
            slot_mispredict[issue_pos] <= issue_mispredict;
        end
    end

    assign cdb_valid      = slot_valid[0];
    assign cdb_tag        = slot_tag[0];
    assign cdb_value      = slot_value[0];
    assign cdb_mispredict = slot_mispredict[0];

endmodule

`default_nettype wire

// ==== arch_regfile.sv ====
`timescale 1ns/100ps
`default_nettype none

module arch_regfile (
    input  logic                                   clock,
    input  logic                                   reset,
    input  logic                                   wr_en,
    input  logic [rob_core_cfg_pkg::reg_idx_w-1:0] wr_idx,
    input  logic [rob_core_cfg_pkg::xlen-1:0]      wr_data,
    input  logic [rob_core_cfg_pkg::reg_idx_w-1:0] rd_idx,
    output logic [rob_core_cfg_pkg::xlen-1:0]      rd_data
);

    import rob_core_cfg_pkg::*;

    logic [xlen-1:0] regs [reg_len];

    always_ff @(posedge clock) begin
        if (reset) begin
            for (int i = 0; i < reg_len; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en && wr_idx != zero_reg) begin
            regs[wr_idx] <= wr_data;
        end
    end

    // register zero is hardwired
    assign rd_data = (rd_idx == zero_reg) ? '0 : regs[rd_idx];

endmodule

`default_nettype wire

// ==== rob_core.sv ====
`timescale 1ns/100ps
`default_nettype none

module rob_core (
    input  logic                                   clock,
    input  logic                                   reset,
    input  logic                                   disp_valid,
    input  rob_core_op_pkg::alu_op_t               disp_op,
    input  logic [rob_core_cfg_pkg::reg_idx_w-1:0] disp_dest,
    input  logic [rob_core_cfg_pkg::xlen-1:0]      disp_a,
    input  logic [rob_core_cfg_pkg::xlen-1:0]      disp_b,
    output logic                                   disp_ready,
    output logic                                   commit_valid,
    output logic [rob_core_cfg_pkg::reg_idx_w-1:0] commit_dest,
    output logic [rob_core_cfg_pkg::xlen-1:0]      commit_value,
    output logic                                   commit_squash,
    input  logic [rob_core_cfg_pkg::reg_idx_w-1:0] rd_idx,
    output logic [rob_core_cfg_pkg::xlen-1:0]      rd_data
);

    import rob_core_cfg_pkg::*;
    import rob_core_op_pkg::*;

    logic                 slot_free;
    logic                 issue_valid;
    logic [rob_tag_w-1:0] issue_tag;
    alu_op_t              issue_op;
    logic [xlen-1:0]      issue_a;
    logic [xlen-1:0]      issue_b;
    logic                 cdb_valid;
    logic [rob_tag_w-1:0] cdb_tag;
    logic [xlen-1:0]      cdb_value;
    logic                 cdb_mispredict;
    logic                 commit_write;
    logic                 flush;

    rob rob_inst (
        .clock, .reset,
        .disp_valid, .disp_op, .disp_dest, .disp_a, .disp_b, .disp_ready,
        .slot_free,
        .issue_valid, .issue_tag, .issue_op, .issue_a, .issue_b,
        .cdb_valid, .cdb_tag, .cdb_value, .cdb_mispredict,
        .commit_valid, .commit_dest, .commit_value, .commit_squash,
        .commit_write,
        .flush
    );

    exec_unit exec_unit_inst (
        .clock, .reset, .flush,
        .issue_valid, .issue_tag, .issue_op, .issue_a, .issue_b,
        .slot_free,
        .cdb_valid, .cdb_tag, .cdb_value, .cdb_mispredict
    );

    arch_regfile arch_regfile_inst (
        .clock   (clock),
        .reset   (reset),
        .wr_en   (commit_write),    // branches and r0 filtered in the rob
        .wr_idx  (commit_dest),
        .wr_data (commit_value),
        .rd_idx  (rd_idx),
        .rd_data (rd_data)
    );

endmodule

`default_nettype wire

// ==== rob_core_assertions.sv ====
`timescale 1ns/100ps
`default_nettype none

module rob_core_assertions (
    input logic                                   clock,
    input logic                                   reset,
    input logic                                   disp_valid,
    input logic                                   disp_ready,
    input logic [rob_core_cfg_pkg::rob_tag_w-1:0] issue_tag,
    input logic                                   cdb_valid,
    input logic                                   commit_valid,
    input logic                                   commit_squash
);

    // a squash retires the head branch and leaves nothing behind
    a_squash_retires: assert property (
        @(posedge clock) disable iff (reset)
            commit_squash |=> $past(commit_valid) && !commit_valid && !cdb_valid
    ) else $error("squash without a retire, or work left in the core after it");

    // tail only moves on a real handshake
    a_no_accept_when_stalled: assert property (
        @(posedge clock) disable iff (reset)
            !(disp_valid && disp_ready) && !commit_squash |=> $stable(issue_tag)
    ) else $error("operation accepted while disp_ready low");

    // state right after a reset edge
    a_idle_after_reset: assert property (
        @(posedge clock) $past(reset) |->
            !commit_valid && !commit_squash && !cdb_valid && disp_ready
    ) else $error("control output active right after reset");

endmodule

`default_nettype wire

// ==== rob_core_tb.sv ====
`timescale 1ns/100ps
`default_nettype none

module rob_core_tb;

    import rob_core_cfg_pkg::*;
    import rob_core_op_pkg::*;

    localparam int seed_init      = 32'h0167_81a8;
    localparam int num_random     = 200;
    localparam int num_burst      = 20;
    localparam int accept_timeout = 40;    // cycles one op may wait for disp_ready
    localparam int drain_timeout  = 100;

    typedef struct packed {
        alu_op_t              op;
        logic [reg_idx_w-1:0] dest;
        logic [xlen-1:0]      a;
        logic [xlen-1:0]      b;
    } op_rec_t;

    logic                 clock;
    logic                 reset;
    logic                 disp_valid;
    alu_op_t              disp_op;
    logic [reg_idx_w-1:0] disp_dest;
    logic [xlen-1:0]      disp_a;
    logic [xlen-1:0]      disp_b;
    logic                 disp_ready;
    logic                 commit_valid;
    logic [reg_idx_w-1:0] commit_dest;
    logic [xlen-1:0]      commit_value;
    logic                 commit_squash;
    logic [reg_idx_w-1:0] rd_idx;
    logic [xlen-1:0]      rd_data;

    op_rec_t         model_q [$];   // accepted and not yet retired, oldest first
    logic [xlen-1:0] model_regs [reg_len];
    int              seed;
    int              discard_count;
    int              squash_count;
    int              branch_ok_count;
    int              ready_low_count;

    rob_core rob_core_inst (
        .clock, .reset,
        .disp_valid, .disp_op, .disp_dest, .disp_a, .disp_b, .disp_ready,
        .commit_valid, .commit_dest, .commit_value, .commit_squash,
        .rd_idx, .rd_data
    );

    bind rob_core rob_core_assertions rob_core_assertions_inst (
        .clock, .reset, .disp_valid, .disp_ready, .issue_tag,
        .cdb_valid, .commit_valid, .commit_squash
    );

    initial begin
        clock = 1'b0;
        forever #10 clock = ~clock;
    end

    // expected result straight from the opcode rules
    function automatic logic [xlen-1:0] expected_result(input alu_op_t op,
            input logic [xlen-1:0] a, input logic [xlen-1:0] b, output logic mispredict);
        mispredict = 1'b0;
        case (op)
            op_and:  return a & b;
            op_xor:  return a ^ b;
            op_add:  return a + b;
            op_sub:  return a - b;
            default: begin
                mispredict = (a == b);   // taken, but predicted not-taken
                return '0;
            end
        endcase
    endfunction

    // add then and, branch then sub, sub then xor all collide in the exec slots
    function automatic alu_op_t burst_op(input int i);
        case (i % 5)
            0:       return op_add;
            1:       return op_and;
            2:       return op_branch;
            3:       return op_sub;
            default: return op_xor;
        endcase
    endfunction

    task automatic abort_sim();
        $display("sim failed");
        $fatal(1, "run stopped at %0t", $realtime);
    endtask

    task automatic compare_value(input string what, input logic [31:0] got,
            input logic [31:0] expected);
        if (got !== expected) begin
            $display("ERR %0t: %s is %h, expected %h", $realtime, what, got, expected);
            abort_sim();
        end
    endtask

    // holds the op on the port until it is taken
    task automatic dispatch_op(input alu_op_t op, input logic [reg_idx_w-1:0] dest,
            input logic [xlen-1:0] a, input logic [xlen-1:0] b);
        int waited;
        @(posedge clock);
        disp_valid <= 1'b1;
        disp_op    <= op;
        disp_dest  <= dest;
        disp_a     <= a;
        disp_b     <= b;
        waited = 0;
        forever begin
            @(negedge clock);
            if (disp_ready) break;      // taken at the coming edge
            ready_low_count++;
            waited++;
            if (waited > accept_timeout) begin
                $display("timeout: operation never accepted by the DUT");
                abort_sim();
            end
        end
        model_q.push_back('{op, dest, a, b});
    endtask

    task automatic insert_gap(input int cycles);
        repeat (cycles) begin
            @(posedge clock);
            disp_valid <= 1'b0;
        end
    endtask

    task automatic send_random_op();
        logic [31:0] r;
        logic [xlen-1:0] a;
        logic [xlen-1:0] b;
        r = $random(seed);
        a = $random(seed);
        b = $random(seed);
        if (r[16]) b = a;   // branches mispredict about half the time
        dispatch_op(alu_op_t'(3'(r % 32'd5)), r[12:8], a, b);
        if (r[21:20] == 2'b00) insert_gap(int'(r[23:22]) + 1);
    endtask

    task automatic wait_for_drain();
        int waited;
        waited = 0;
        while (model_q.size() != 0) begin
            @(negedge clock);
            waited++;
            if (waited > drain_timeout) begin
                $display("timeout: outstanding operations never retired");
                abort_sim();
            end
        end
    endtask

    // retire checker, in program order
    initial begin : compare_commits
        op_rec_t         oldest;
        logic [xlen-1:0] exp_value;
        logic            exp_mis;
        forever begin
            @(negedge clock);
            if (!reset && commit_valid) begin
                if (model_q.size() == 0) begin
                    $display("commit seen with no outstanding operation");
                    abort_sim();
                end
                oldest    = model_q.pop_front();
                exp_value = expected_result(oldest.op, oldest.a, oldest.b, exp_mis);
                compare_value("commit_dest", 32'(commit_dest), 32'(oldest.dest));
                compare_value("commit_value", commit_value, exp_value);
                compare_value("commit_squash", 32'(commit_squash), 32'(exp_mis));
                if (oldest.op != op_branch && oldest.dest != zero_reg)
                    model_regs[oldest.dest] = exp_value;
                if (exp_mis) begin
                    discard_count += model_q.size();   // younger ops die with the branch
                    model_q.delete();
                    squash_count++;
                end else if (oldest.op == op_branch) begin
                    branch_ok_count++;
                end
            end else if (!reset && commit_squash) begin
                compare_value("commit_valid during squash", 32'(commit_valid), 32'd1);
            end
        end
    end

    initial begin : stimulus
        int i;
        int mark;
        $timeformat(-9, 1, " ns", 0);
        seed = seed_init;
        foreach (model_regs[k]) model_regs[k] = '0;
        reset      <= 1'b1;
        disp_valid <= 1'b0;
        disp_op    <= op_and;
        disp_dest  <= '0;
        disp_a     <= '0;
        disp_b     <= '0;
        rd_idx     <= '0;
        repeat (3) @(posedge clock);
        reset <= 1'b0;
        @(negedge clock);
        compare_value("disp_ready after reset", 32'(disp_ready), 32'd1);
        compare_value("commit_valid after reset", 32'(commit_valid), 32'd0);
        compare_value("commit_squash after reset", 32'(commit_squash), 32'd0);

        for (i = 0; i < num_random; i++) send_random_op();
        insert_gap(1);
        wait_for_drain();

        // back-to-back stream, branch operands never equal here
        mark = ready_low_count;
        for (i = 0; i < num_burst; i++)
            dispatch_op(burst_op(i), reg_idx_w'(i + 1), xlen'(100 + i), xlen'(3 * i + 1));
        insert_gap(1);
        wait_for_drain();
        compare_value("disp_ready dropped in burst", 32'(ready_low_count > mark), 32'd1);

        // mispredicted branch with younger ops right behind it
        mark = discard_count;
        dispatch_op(op_branch, 5'd3, 32'h55, 32'h55);
        for (i = 0; i < 5; i++) dispatch_op(op_add, reg_idx_w'(10 + i), 32'd1000, xlen'(i));
        insert_gap(1);
        wait_for_drain();
        compare_value("younger ops squashed", 32'(discard_count > mark), 32'd1);

        // correctly predicted branch, younger ops must retire
        mark = branch_ok_count;
        dispatch_op(op_branch, 5'd4, 32'h12, 32'h34);
        for (i = 0; i < 4; i++) dispatch_op(op_xor, reg_idx_w'(20 + i), 32'hf0f0, xlen'(i));
        insert_gap(1);
        wait_for_drain();
        compare_value("unequal branch retired", 32'(branch_ok_count > mark), 32'd1);

        for (i = 0; i < reg_len; i++) begin
            @(posedge clock);
            rd_idx <= reg_idx_w'(i);
            @(negedge clock);
            compare_value($sformatf("register %0d", i), rd_data, model_regs[i]);
        end
        $display("sim passed");
        $finish;
    end

endmodule

`default_nettype wire

// ==== rob_core.f ====
rob_core_cfg_pkg.sv
rob_core_op_pkg.sv
rob_entry.sv
rob.sv
exec_unit.sv
arch_regfile.sv
rob_core.sv
rob_core_assertions.sv
rob_core_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build and run the rob_core testbench with verilator
set -u
cd "$(dirname "$0")" || exit 1

top=rob_core_tb
build_dir=obj_dir

if ! command -v verilator >/dev/null 2>&1; then
    echo "verilator not found in PATH"
    exit 1
fi

if ! verilator --binary --timing --assert -j 0 \
        --top-module "$top" --Mdir "$build_dir" -o "$top" -f rob_core.f; then
    echo "build failed"
    exit 1
fi

sim_out=$("./$build_dir/$top" 2>&1)
sim_status=$?
echo "$sim_out"

if [ "$sim_status" -ne 0 ]; then
    echo "simulation exited with status $sim_status"
    exit 1
fi

if grep -qx "sim passed" <<< "$sim_out"; then
    exit 0
fi
echo "pass message not found"
exit 1
